// ==== src/bridge_defines.svh ====
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define ADDR_W          32
`define DATA_W          32

// Four APB slaves behind the bridge
`define NUM_APB_SLAVES  4

// ------------------------------
// APB slave address windows
// ------------------------------
// Each window is 4 KB, packed back to back from 0x4000_0000
`define APB_SLAVE0_START 32'h4000_0000
`define APB_SLAVE0_END   32'h4000_0FFF
`define APB_SLAVE1_START 32'h4000_1000
`define APB_SLAVE1_END   32'h4000_1FFF
`define APB_SLAVE2_START 32'h4000_2000
`define APB_SLAVE2_END   32'h4000_2FFF
`define APB_SLAVE3_START 32'h4000_3000
`define APB_SLAVE3_END   32'h4000_3FFF

`endif

// ==== src/ahb_pkg.sv ====
`default_nettype none

`include "bridge_defines.svh"

package ahb_pkg;

  // Bus address and data words
  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`DATA_W-1:0] data_t;

  // HTRANS encodings
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Only OKAY is ever returned by the bridge
  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01
  } hresp_e;

endpackage

`default_nettype wire

// ==== src/apb_pkg.sv ====
`default_nettype none

`include "bridge_defines.svh"

package apb_pkg;

  // Address and data words are shared with the AHB side
  import ahb_pkg::addr_t;
  import ahb_pkg::data_t;
  export ahb_pkg::addr_t;
  export ahb_pkg::data_t;

  // One bit per APB slave, at most one set
  typedef logic [`NUM_APB_SLAVES-1:0] slave_sel_t;

  // One-hot APB sequencer states
  typedef enum logic [2:0] {
    APB_IDLE   = 3'b001,
    APB_SETUP  = 3'b010,
    APB_ACCESS = 3'b100
  } apb_state_e;

endpackage

`default_nettype wire

// ==== src/ahb_slave_if.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_slave_if
  import ahb_pkg::*;
(
  input  wire logic    hclk16,
  input  wire logic    hreset_n16,

  // AHB address phase inputs
  input  wire logic    hsel,
  input  wire addr_t   haddr,
  input  wire htrans_e htrans,
  input  wire logic    hwrite,

  // Completion from the APB side
  input  wire logic    done,
  input  wire data_t   prdata_sel,

  output logic         hready,
  output logic         accept,
  output logic         data_phase,
  output addr_t        haddr_q,
  output logic         hwrite_q,
  output data_t        hrdata
);

  logic valid_trans;

  // ------------------------------
  // Transfer qualification
  // ------------------------------
  // Only NONSEQ and SEQ carry a transfer, IDLE and BUSY are dropped
  assign valid_trans = hsel && ((htrans == NONSEQ) || (htrans == SEQ));
  assign accept      = hready && valid_trans;

  // Data phase lasts as long as hready is held low
  assign data_phase  = ~hready;

  // ------------------------------
  // Phase tracking and read data
  // ------------------------------
  always_ff @(posedge hclk16 or negedge hreset_n16) begin
    if (!hreset_n16) begin
      hready <= 1'b1;
      hrdata <= '0;
    end else if (accept) begin
      hready <= 1'b0;
    end else if (done) begin
      // Slave finished, release the bus with its read data
      hready <= 1'b1;
      hrdata <= prdata_sel;
    end
  end

  // Address and direction held for the whole APB access
  always_ff @(posedge hclk16) begin
    if (accept) begin
      haddr_q  <= haddr;
      hwrite_q <= hwrite;
    end
  end

endmodule

`default_nettype wire

// ==== src/apb_slave_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defines.svh"

module apb_slave_decoder
  import ahb_pkg::*;
  import apb_pkg::*;
(
  input  wire logic       hclk16,
  input  wire logic       hreset_n16,

  // Decode request from the AHB side
  input  wire logic       accept,
  input  wire addr_t      haddr,

  // APB select and slave returns
  input  wire slave_sel_t psel,
  input  wire slave_sel_t pready,
  input  wire data_t      prdata0,
  input  wire data_t      prdata1,
  input  wire data_t      prdata2,
  input  wire data_t      prdata3,

  output slave_sel_t      slave_select,
  output logic            pready_sel,
  output data_t           prdata_sel
);

  // Window bounds indexed by slave number
  localparam addr_t win_start [`NUM_APB_SLAVES] = '{
    `APB_SLAVE0_START, `APB_SLAVE1_START, `APB_SLAVE2_START, `APB_SLAVE3_START
  };
  localparam addr_t win_end [`NUM_APB_SLAVES] = '{
    `APB_SLAVE0_END, `APB_SLAVE1_END, `APB_SLAVE2_END, `APB_SLAVE3_END
  };

  slave_sel_t hit;
  data_t      prdata_arr [`NUM_APB_SLAVES];

  // ------------------------------
  // Address window decode
  // ------------------------------
  always_comb begin
    hit = '0;
    for (int i = 0; i < `NUM_APB_SLAVES; i++) begin
      hit[i] = (haddr >= win_start[i]) && (haddr <= win_end[i]);
    end
  end

  // Select is frozen at accept, valid from the next cycle
  always_ff @(posedge hclk16 or negedge hreset_n16) begin
    if (!hreset_n16) begin
      slave_select <= '0;
    end else if (accept) begin
      slave_select <= hit;
    end
  end

  // ------------------------------
  // Return path
  // ------------------------------
  assign prdata_arr[0] = prdata0;
  assign prdata_arr[1] = prdata1;
  assign prdata_arr[2] = prdata2;
  assign prdata_arr[3] = prdata3;

  // AND-OR mux, only the active psel contributes
  always_comb begin
    pready_sel = 1'b0;
    prdata_sel = '0;
    for (int i = 0; i < `NUM_APB_SLAVES; i++) begin
      pready_sel = pready_sel | (psel[i] & pready[i]);
      prdata_sel = prdata_sel | (prdata_arr[i] & {`DATA_W{psel[i]}});
    end
  end

endmodule

`default_nettype wire

// ==== src/apb_master_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_master_fsm
  import ahb_pkg::*;
  import apb_pkg::*;
(
  input  wire logic       hclk16,
  input  wire logic       hreset_n16,

  // Pending transfer from the AHB side
  input  wire logic       data_phase,
  input  wire slave_sel_t slave_select,
  input  wire addr_t      haddr_q,
  input  wire logic       hwrite_q,

  // Ready of the selected slave
  input  wire logic       pready_sel,

  // APB master outputs
  output slave_sel_t      psel,
  output logic            penable,
  output addr_t           paddr,
  output logic            pwrite,

  output logic            done
);

  apb_state_e state;

  // Transfer completes on the ACCESS cycle the slave is ready
  assign done = (state == APB_ACCESS) && pready_sel;

  // ------------------------------
  // APB sequencer
  // ------------------------------
  always_ff @(posedge hclk16 or negedge hreset_n16) begin
    if (!hreset_n16) begin
      state   <= APB_IDLE;
      psel    <= '0;
      penable <= 1'b0;
      paddr   <= '0;
      pwrite  <= 1'b0;
    end else begin
      case (state)
        APB_IDLE: begin
          // Load the captured transfer and enter SETUP
          if (data_phase) begin
            state  <= APB_SETUP;
            psel   <= slave_select;
            paddr  <= haddr_q;
            pwrite <= hwrite_q;
          end
        end

        APB_SETUP: begin
          state   <= APB_ACCESS;
          penable <= 1'b1;
        end

        APB_ACCESS: begin
          // Hold everything while the slave inserts wait states
          if (pready_sel) begin
            state   <= APB_IDLE;
            psel    <= '0;
            penable <= 1'b0;
          end
        end

        default: begin
          state   <= APB_IDLE;
          psel    <= '0;
          penable <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/ahb2apb_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defines.svh"

module ahb2apb_bridge
  import ahb_pkg::*;
  import apb_pkg::*;
(
  input  wire logic                       hclk16,
  input  wire logic                       hreset_n16,

  // AHB slave port
  input  wire logic                       hsel,
  input  wire addr_t                      haddr,
  input  wire htrans_e                    htrans,
  input  wire data_t                      hwdata,
  input  wire logic                       hwrite,
  output data_t                           hrdata,
  output logic                            hready,
  output hresp_e                          hresp,

  // APB master port, common signals
  output addr_t                           paddr,
  output logic                            penable,
  output logic                            pwrite,
  output data_t                           pwdata,
  output slave_sel_t                      psel,

  // Per-slave returns
  input  wire logic [`NUM_APB_SLAVES-1:0] pready,
  input  wire data_t                      prdata0,
  input  wire data_t                      prdata1,
  input  wire data_t                      prdata2,
  input  wire data_t                      prdata3
);

  logic       accept;
  logic       data_phase;
  addr_t      haddr_q;
  logic       hwrite_q;
  logic       done;
  slave_sel_t slave_select;
  logic       pready_sel;
  data_t      prdata_sel;

  // Write data is held by the master until hready rises
  assign pwdata = hwdata;

  // No error responses
  assign hresp = OKAY;

  // ------------------------------
  // AHB side
  // ------------------------------
  ahb_slave_if u_ahb_slave_if (
    .hclk16     (hclk16),
    .hreset_n16 (hreset_n16),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .done       (done),
    .prdata_sel (prdata_sel),
    .hready     (hready),
    .accept     (accept),
    .data_phase (data_phase),
    .haddr_q    (haddr_q),
    .hwrite_q   (hwrite_q),
    .hrdata     (hrdata)
  );

  // Decode on the live address, mux returns by psel
  apb_slave_decoder u_apb_slave_decoder (
    .hclk16       (hclk16),
    .hreset_n16   (hreset_n16),
    .accept       (accept),
    .haddr        (haddr),
    .psel         (psel),
    .pready       (pready),
    .prdata0      (prdata0),
    .prdata1      (prdata1),
    .prdata2      (prdata2),
    .prdata3      (prdata3),
    .slave_select (slave_select),
    .pready_sel   (pready_sel),
    .prdata_sel   (prdata_sel)
  );

  // ------------------------------
  // APB side
  // ------------------------------
  apb_master_fsm u_apb_master_fsm (
    .hclk16       (hclk16),
    .hreset_n16   (hreset_n16),
    .data_phase   (data_phase),
    .slave_select (slave_select),
    .haddr_q      (haddr_q),
    .hwrite_q     (hwrite_q),
    .pready_sel   (pready_sel),
    .psel         (psel),
    .penable      (penable),
    .paddr        (paddr),
    .pwrite       (pwrite),
    .done         (done)
  );

endmodule

`default_nettype wire

// ==== tests/tb_apb_slave_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_apb_slave_model
  import ahb_pkg::*;
#(
  parameter int    WAIT_CYCLES = 0,
  parameter addr_t BASE_ADDR   = 32'h4000_0000
) (
  input  wire logic  hclk16,
  input  wire logic  hreset_n16,

  // APB slave port
  input  wire logic  psel,
  input  wire logic  penable,
  input  wire logic  pwrite,
  input  wire addr_t paddr,
  input  wire data_t pwdata,
  output logic       pready,
  output data_t      prdata
);

  // 16 words, indexed by paddr[5:2]
  data_t mem [16];
  int    wait_cnt;

  // Ready once this access has sat out its wait states
  assign pready = psel && penable && (wait_cnt == WAIT_CYCLES);

  // Read data valid for the whole ACCESS phase
  assign prdata = (psel && penable) ? mem[paddr[5:2]] : '0;

  always_ff @(posedge hclk16 or negedge hreset_n16) begin
    if (!hreset_n16) begin
      wait_cnt <= 0;
      // Fill pattern taken from the full word address
      for (int i = 0; i < 16; i++) begin
        mem[i] <= (BASE_ADDR + (32'(i) << 2)) ^ 32'h3C3C_C3C3;
      end
    end else begin
      if (psel && penable && !pready) begin
        wait_cnt <= wait_cnt + 1;
      end else begin
        wait_cnt <= 0;
      end
      // Write lands on the completing cycle
      if (pready && pwrite) begin
        mem[paddr[5:2]] <= pwdata;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_ahb2apb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defines.svh"

module tb_ahb2apb
  import ahb_pkg::*;
();

  logic                       hclk16;
  logic                       hreset_n16;
  logic                       hsel;
  addr_t                      haddr;
  htrans_e                    htrans;
  data_t                      hwdata;
  logic                       hwrite;
  data_t                      hrdata;
  logic                       hready;
  hresp_e                     hresp;
  addr_t                      paddr;
  logic                       penable;
  logic                       pwrite;
  data_t                      pwdata;
  logic [`NUM_APB_SLAVES-1:0] psel;
  wire  [`NUM_APB_SLAVES-1:0] pready;
  wire data_t                 prdata_arr [`NUM_APB_SLAVES];
  data_t                      ref_mem [`NUM_APB_SLAVES][16];
  integer                     seed;
  int                         errors;
  int                         tests;
  int                         fails;
  int                         cycles;

  // Wait states per slave are 0, 1, 3 and 0
  function automatic int wait_cycles_of(int slave);
    return (slave == 1) ? 1 : (slave == 2) ? 3 : 0;
  endfunction

  // 4 KB windows from 0x4000_0000
  function automatic addr_t word_addr(int slave, int word);
    return 32'h4000_0000 + (32'(slave) << 12) + (32'(word) << 2);
  endfunction

  function automatic data_t fill_value(addr_t a);
    return a ^ 32'h3C3C_C3C3;
  endfunction

  ahb2apb_bridge dut (
    .*,
    .prdata0 (prdata_arr[0]),
    .prdata1 (prdata_arr[1]),
    .prdata2 (prdata_arr[2]),
    .prdata3 (prdata_arr[3])
  );

  for (genvar gi = 0; gi < `NUM_APB_SLAVES; gi++) begin : g_slave
    tb_apb_slave_model #(
      .WAIT_CYCLES (wait_cycles_of(gi)),
      .BASE_ADDR   (word_addr(gi, 0))
    ) u_slave (
      .*,
      .psel   (psel[gi]),
      .pready (pready[gi]),
      .prdata (prdata_arr[gi])
    );
  end

  initial begin
    hclk16 = 1'b0;
    forever #10 hclk16 = ~hclk16;
  end

  // Some 40 transfers of under 10 cycles each stay far below 4000 cycles
  always @(posedge hclk16) begin
    cycles <= cycles + 1;
    if (cycles == 4000) begin
      $display("Timeout: the tests did not finish within 4000 cycles");
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ------------------------------
  // Reporting
  // ------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic finish_test(input string name, input int start_errors);
    tests++;
    if (errors == start_errors) begin
      $display("%-12s ok", name);
    end else begin
      fails++;
      $display("%-12s %0d errors", name, errors - start_errors);
    end
  endtask

  // ------------------------------
  // AHB driver
  // ------------------------------
  // One transfer with APB phase checks while hready is low
  task automatic run_transfer(input addr_t addr, input logic write, input data_t wdata,
                              output data_t rdata, output int low);
    logic [`NUM_APB_SLAVES-1:0] exp_sel;
    int                         setup;
    exp_sel = 4'b0001 << addr[13:12];
    setup = 0;
    low = 0;
    @(posedge hclk16);
    #1;
    while (!hready) begin
      @(posedge hclk16);
      #1;
    end
    hsel = 1'b1;
    haddr = addr;
    htrans = NONSEQ;
    hwrite = write;
    // Write data follows in the data phase after the accept edge
    @(posedge hclk16);
    #1;
    hsel = 1'b0;
    htrans = IDLE;
    hwdata = wdata;
    @(negedge hclk16);
    while (!hready) begin
      low++;
      if (psel != '0) begin
        if (psel !== exp_sel) report_mismatch("psel", 32'(psel), 32'(exp_sel));
        if (paddr !== addr) report_mismatch("paddr", paddr, addr);
        if (pwrite !== write) report_mismatch("pwrite", 32'(pwrite), 32'(write));
        if (write && (pwdata !== wdata)) report_mismatch("pwdata", pwdata, wdata);
        if (!penable) begin
          setup++;
        end else if (setup != 1) begin
          $display("FAILED at %0t: penable rose after %0d setup cycles", $time, setup);
          errors++;
        end
      end
      @(negedge hclk16);
    end
    if (psel !== '0) report_mismatch("psel", 32'(psel), 0);
    if (penable !== 1'b0) report_mismatch("penable", 32'(penable), 0);
    rdata = hrdata;
  endtask

  task automatic ahb_write(input addr_t addr, input data_t data, output int low);
    data_t unused;
    run_transfer(addr, 1'b1, data, unused, low);
    ref_mem[addr[13:12]][addr[5:2]] = data;
  endtask

  task automatic ahb_read(input addr_t addr, output int low);
    data_t rdata;
    run_transfer(addr, 1'b0, '0, rdata, low);
    if (rdata !== ref_mem[addr[13:12]][addr[5:2]]) begin
      report_mismatch("hrdata", rdata, ref_mem[addr[13:12]][addr[5:2]]);
    end
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic reset_values();
    int start;
    start = errors;
    if (hready !== 1'b1) report_mismatch("hready", 32'(hready), 1);
    if (psel !== '0) report_mismatch("psel", 32'(psel), 0);
    if (penable !== 1'b0) report_mismatch("penable", 32'(penable), 0);
    if (hresp !== OKAY) report_mismatch("hresp", 32'(hresp), 32'(OKAY));
    if (hrdata !== '0) report_mismatch("hrdata", hrdata, 0);
    if (paddr !== '0) report_mismatch("paddr", paddr, 0);
    finish_test("reset", start);
  endtask

  task automatic write_read_all();
    int start;
    int low;
    start = errors;
    for (int s = 0; s < `NUM_APB_SLAVES; s++) begin
      ahb_write(word_addr(s, 5 + s), 32'hC0DE_0000 | 32'(s * 257 + 7), low);
      ahb_read(word_addr(s, 5 + s), low);
    end
    finish_test("write_read", start);
  endtask

  // One write and one read per window, each with the per-transfer phase checks
  task automatic apb_phases();
    int start;
    int low;
    start = errors;
    for (int s = 0; s < `NUM_APB_SLAVES; s++) begin
      ahb_write(word_addr(s, 15), $random(seed), low);
      ahb_read(word_addr(s, 15), low);
    end
    finish_test("apb_phases", start);
  endtask

  task automatic wait_latency();
    int start;
    int low;
    start = errors;
    for (int s = 0; s < `NUM_APB_SLAVES; s++) begin
      ahb_read(word_addr(s, 1), low);
      if (low != 3 + wait_cycles_of(s)) begin
        report_mismatch("hready low cycles", 32'(low), 32'(3 + wait_cycles_of(s)));
      end
    end
    finish_test("latency", start);
  endtask

  task automatic hold_ignored(input logic sel, input htrans_e trans);
    @(posedge hclk16);
    #1;
    hsel = sel;
    haddr = word_addr(2, 4);
    htrans = trans;
    repeat (4) begin
      @(negedge hclk16);
      if (hready !== 1'b1) report_mismatch("hready", 32'(hready), 1);
      if (psel !== '0) report_mismatch("psel", 32'(psel), 0);
    end
  endtask

  task automatic ignored_transfers();
    int start;
    start = errors;
    hold_ignored(1'b1, IDLE);
    hold_ignored(1'b1, BUSY);
    hold_ignored(1'b0, NONSEQ);
    hold_ignored(1'b0, IDLE);
    finish_test("ignored", start);
  endtask

  task automatic random_traffic();
    int    start;
    int    low;
    addr_t addr;
    start = errors;
    for (int n = 0; n < 20; n++) begin
      addr = word_addr($unsigned($random(seed)) % 4, $unsigned($random(seed)) % 16);
      if (($random(seed) & 1) != 0) begin
        ahb_write(addr, $random(seed), low);
      end else begin
        ahb_read(addr, low);
      end
    end
    finish_test("random", start);
  endtask

  initial begin
    seed = 32'h3667b00f;
    hreset_n16 = 1'b0;
    hsel = 1'b0;
    haddr = '0;
    htrans = IDLE;
    hwdata = '0;
    hwrite = 1'b0;
    // Reference starts from the slave memories' fill pattern
    for (int s = 0; s < `NUM_APB_SLAVES; s++) begin
      for (int w = 0; w < 16; w++) begin
        ref_mem[s][w] = fill_value(word_addr(s, w));
      end
    end
    repeat (10) @(posedge hclk16);
    #1;
    hreset_n16 = 1'b1;
    @(negedge hclk16);
    reset_values();
    write_read_all();
    apb_phases();
    wait_latency();
    ignored_transfers();
    random_traffic();
    $display("%0d tests run, %0d failed, %0d check errors", tests, fails, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/ahb_pkg.sv
src/apb_pkg.sv
src/ahb_slave_if.sv
src/apb_slave_decoder.sv
src/apb_master_fsm.sv
src/ahb2apb_bridge.sv
tests/tb_apb_slave_model.sv
tests/tb_ahb2apb.sv

// ==== Makefile ====
SOURCES := tb.f $(wildcard src/*.sv src/*.svh tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_ahb2apb: $(SOURCES)
	verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_ahb2apb -f tb.f

run: obj_dir/Vtb_ahb2apb
	./obj_dir/Vtb_ahb2apb | tee sim.log
	@grep -q "=== PASS ===" sim.log && ! grep -q "=== FAIL ===" sim.log

clean:
	rm -rf obj_dir sim.log
